//--- filelist.f
src/fpss_pkg.sv
src/fpss_dec_if.sv
src/fpss_instr_fifo.sv
src/fpss_decoder.sv
src/fpss_controller.sv
src/fpss_exec_unit.sv
src/fpss_regfile.sv
src/fpss_top.sv
verif/tb_fpss.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps -Wno-fatal --top-module tb_fpss \
  -f filelist.f > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_fpss > sim.log 2>&1 || { cat sim.log; echo "Simulation exited abnormally"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- verif/tb_fpss.sv
`timescale 1ns/10ps

module tb_fpss import fpss_pkg::*; ();

  localparam int    NUM_INSTR   = 300;
  localparam int    TIMEOUT_CYC = NUM_INSTR * 20;
  // Loads and stores share 16 words so stores get read back
  localparam word_t MEM_BASE    = 32'h0000_1000;

  logic     clk_i;
  logic     rst_ni;
  logic     in_valid_i;
  instr_t   in_instr_i;
  word_t    in_operand_i;
  logic     in_ready_o;
  logic     c_p_ready_i;
  logic     c_p_valid_o;
  word_t    c_p_data_o;
  logic     cmem_q_ready_i;
  logic     cmem_q_valid_o;
  mem_req_e cmem_q_type_o;
  word_t    cmem_q_addr_o;
  word_t    cmem_q_wdata_o;
  logic     cmem_p_valid_i;
  word_t    cmem_p_data_i;

  integer seed;
  int     err_mismatch;
  int     err_other;
  int     n_rsp_chk;
  int     n_req_chk;
  int     n_acc;
  int     held;
  int     cycle_cnt;
  int     rsp_wait;
  int     c_stall;
  int     m_stall;
  logic   in_hs;
  logic   load_req;
  word_t  load_addr;
  logic   cp_wait_q;
  logic   mq_wait_q;
  word_t  mq_addr_q;

  // Reference model in program order
  word_t m_fpr [NUM_FPR];
  word_t m_csr;
  word_t m_mem [word_t];
  // Memory behind the responder that the DUT's store requests write
  word_t bus_mem [word_t];

  // Expected core responses and memory requests with the oldest first
  word_t    exp_rsp [$];
  mem_req_e exp_type [$];
  word_t    exp_addr [$];
  word_t    exp_wdata [$];

  fpss_top i_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_valid_i     (in_valid_i),
    .in_instr_i     (in_instr_i),
    .in_operand_i   (in_operand_i),
    .in_ready_o     (in_ready_o),
    .c_p_ready_i    (c_p_ready_i),
    .c_p_valid_o    (c_p_valid_o),
    .c_p_data_o     (c_p_data_o),
    .cmem_q_ready_i (cmem_q_ready_i),
    .cmem_q_valid_o (cmem_q_valid_o),
    .cmem_q_type_o  (cmem_q_type_o),
    .cmem_q_addr_o  (cmem_q_addr_o),
    .cmem_q_wdata_o (cmem_q_wdata_o),
    .cmem_p_valid_i (cmem_p_valid_i),
    .cmem_p_data_i  (cmem_p_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic compare_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      err_mismatch++;
      $display("mismatch at %0t: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic compare_type(input string what, input mem_req_e got, input mem_req_e exp);
    if (got !== exp) begin
      err_mismatch++;
      $display("mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  // Initial memory contents mixed from the whole address
  function automatic word_t fill_word(input word_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic word_t model_mem_rd(input word_t addr);
    if (m_mem.exists(addr)) begin
      return m_mem[addr];
    end
    return fill_word(addr);
  endfunction

  function automatic word_t bus_mem_rd(input word_t addr);
    if (bus_mem.exists(addr)) begin
      return bus_mem[addr];
    end
    return fill_word(addr);
  endfunction

  task automatic make_instr(input int idx, output instr_t instr, output word_t operand);
    opcode_e  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    rd      = reg_idx_t'($random(seed));
    rs1     = reg_idx_t'($random(seed));
    rs2     = reg_idx_t'($random(seed));
    operand = $random(seed);
    if (idx < NUM_FPR) begin
      // Known start value in every register
      op = OP_MVW;
      rd = reg_idx_t'(idx);
    end else if (idx >= NUM_INSTR - NUM_FPR) begin
      // Read every register back at the end
      op  = OP_MVX;
      rs1 = reg_idx_t'(idx - (NUM_INSTR - NUM_FPR));
    end else begin
      op = opcode_e'(3'($unsigned($random(seed)) % 7));
    end
    if (op == OP_LOAD || op == OP_STORE) begin
      operand = MEM_BASE | (operand & 32'h0000_003c);
    end
    instr = {op, rd, rs1, rs2};
  endtask

  // Executes one accepted instruction on the model
  task automatic model_accept(input instr_t instr, input word_t operand);
    opcode_e  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    op  = opcode_e'(instr[OPC_MSB:OPC_LSB]);
    rd  = instr[RD_MSB:RD_LSB];
    rs1 = instr[RS1_MSB:RS1_LSB];
    rs2 = instr[RS2_MSB:RS2_LSB];
    case (op)
      OP_ADD: m_fpr[rd] = m_fpr[rs1] + m_fpr[rs2];
      // Low 32 bits of the product
      OP_MUL: m_fpr[rd] = m_fpr[rs1] * m_fpr[rs2];
      OP_MVW: m_fpr[rd] = operand;
      OP_MVX: exp_rsp.push_back(m_fpr[rs1]);
      OP_LOAD: begin
        exp_type.push_back(MEM_READ);
        exp_addr.push_back(operand);
        exp_wdata.push_back('0);
        m_fpr[rd] = model_mem_rd(operand);
      end
      OP_STORE: begin
        exp_type.push_back(MEM_WRITE);
        exp_addr.push_back(operand);
        exp_wdata.push_back(m_fpr[rs2]);
        m_mem[operand] = m_fpr[rs2];
      end
      // Old CSR value goes back before the write
      OP_CSRW: begin
        exp_rsp.push_back(m_csr);
        m_csr = operand;
      end
      default: ;
    endcase
  endtask

  task automatic take_mem_req();
    mem_req_e typ;
    word_t    addr;
    word_t    wdata;
    typ   = exp_type.pop_front();
    addr  = exp_addr.pop_front();
    wdata = exp_wdata.pop_front();
    n_req_chk++;
    compare_type("memory request type", cmem_q_type_o, typ);
    compare_word("memory request address", cmem_q_addr_o, addr);
    if (typ == MEM_WRITE) begin
      compare_word("store data", cmem_q_wdata_o, wdata);
      bus_mem[cmem_q_addr_o] = cmem_q_wdata_o;
    end else begin
      // Responder answers in a few cycles
      load_req  = 1'b1;
      load_addr = cmem_q_addr_o;
    end
  endtask

  task automatic expect_reset_state();
    if (in_ready_o !== 1'b1) begin
      err_other++;
      $display("in_ready_o is not high after reset");
    end
    if (c_p_valid_o !== 1'b0 || cmem_q_valid_o !== 1'b0) begin
      err_other++;
      $display("a response or memory request is valid right after reset");
    end
  endtask

  // One falling edge worth of input changes
  task automatic drive_step();
    instr_t instr;
    word_t  operand;
    @(negedge clk_i);
    if (in_valid_i && in_hs) begin
      in_valid_i = 1'b0;
    end
    if (!in_valid_i && n_acc < NUM_INSTR && ($random(seed) & 3) != 0) begin
      make_instr(n_acc, instr, operand);
      in_instr_i   = instr;
      in_operand_i = operand;
      in_valid_i   = 1'b1;
    end
    // Ready lines now and then held low for several cycles
    if (c_stall > 0) begin
      c_stall--;
      c_p_ready_i = 1'b0;
    end else if (($random(seed) & 15) == 0) begin
      c_stall     = 6;
      c_p_ready_i = 1'b0;
    end else begin
      c_p_ready_i = ($random(seed) & 3) != 0;
    end
    if (m_stall > 0) begin
      m_stall--;
      cmem_q_ready_i = 1'b0;
    end else if (($random(seed) & 15) == 0) begin
      m_stall        = 6;
      cmem_q_ready_i = 1'b0;
    end else begin
      cmem_q_ready_i = ($random(seed) & 3) != 0;
    end
    // Memory responder answers 1 to 4 cycles after a read request
    cmem_p_valid_i = 1'b0;
    cmem_p_data_i  = $random(seed);
    if (load_req) begin
      load_req = 1'b0;
      rsp_wait = 1 + ($random(seed) & 3);
    end
    if (rsp_wait > 0) begin
      rsp_wait--;
      if (rsp_wait == 0) begin
        cmem_p_valid_i = 1'b1;
        cmem_p_data_i  = bus_mem_rd(load_addr);
      end
    end
  endtask

  task automatic finish_run();
    $display("%0d mismatches, %0d other errors, %0d responses and %0d memory requests checked",
             err_mismatch, err_other, n_rsp_chk, n_req_chk);
    if (err_mismatch + err_other == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // Monitor samples at the rising edge before any register updates
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle_cnt++;
      if (cp_wait_q && !c_p_valid_o) begin
        err_other++;
        $display("core response valid dropped before its handshake at %0t", $time);
      end
      if (mq_wait_q && (!cmem_q_valid_o || cmem_q_addr_o !== mq_addr_q)) begin
        err_other++;
        $display("memory request changed before its handshake at %0t", $time);
      end
      if (c_p_valid_o && c_p_ready_i) begin
        if (exp_rsp.size() == 0) begin
          err_other++;
          $display("core response at %0t with no instruction expecting one", $time);
        end else begin
          n_rsp_chk++;
          compare_word("core response", c_p_data_o, exp_rsp.pop_front());
        end
      end
      if (cmem_q_valid_o && cmem_q_ready_i) begin
        if (exp_type.size() == 0) begin
          err_other++;
          $display("memory request at %0t with no load or store pending", $time);
        end else begin
          take_mem_req();
        end
      end
      cp_wait_q = c_p_valid_o & ~c_p_ready_i;
      mq_wait_q = cmem_q_valid_o & ~cmem_q_ready_i;
      mq_addr_q = cmem_q_addr_o;
      // Buffer room against the count of unretired entries
      if (in_ready_o !== (held < FIFO_DEPTH)) begin
        err_other++;
        $display("in_ready_o does not match %0d held entries at %0t", held, $time);
      end
      in_hs = in_valid_i & in_ready_o;
      if (in_hs) begin
        model_accept(in_instr_i, in_operand_i);
        n_acc++;
      end
      held = held + int'(in_hs) - int'(i_dut.pop_valid & i_dut.pop_ready);
      if (held > FIFO_DEPTH) begin
        err_other++;
        $display("buffer holds more than %0d unretired entries at %0t", FIFO_DEPTH, $time);
      end
    end
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYC);
    err_other++;
    $display("timeout after %0d cycles, %0d responses and %0d memory requests never came",
             cycle_cnt, exp_rsp.size(), exp_type.size());
    finish_run();
  end

  initial begin
    seed           = 32'hb163;
    rst_ni         = 1'b0;
    in_valid_i     = 1'b0;
    in_instr_i     = '0;
    in_operand_i   = '0;
    c_p_ready_i    = 1'b0;
    cmem_q_ready_i = 1'b0;
    cmem_p_valid_i = 1'b0;
    cmem_p_data_i  = '0;
    in_hs          = 1'b0;
    load_req       = 1'b0;
    load_addr      = '0;
    cp_wait_q      = 1'b0;
    mq_wait_q      = 1'b0;
    mq_addr_q      = '0;
    m_csr          = '0;
    for (int i = 0; i < NUM_FPR; i++) begin
      m_fpr[i] = '0;
    end
    repeat (5) @(negedge clk_i);
    expect_reset_state();
    rst_ni = 1'b1;
    while (n_acc < NUM_INSTR || exp_rsp.size() != 0 || exp_type.size() != 0 || rsp_wait != 0) begin
      drive_step();
    end
    // Quiet tail catches late or repeated responses
    repeat (20) drive_step();
    if (held != 0) begin
      err_other++;
      $display("buffer still holds %0d entries after the last response", held);
    end
    finish_run();
  end

endmodule

//--- src/fpss_top.sv
`timescale 1ns/10ps

module fpss_top import fpss_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Offload from the core
  input  logic     in_valid_i,
  input  instr_t   in_instr_i,
  input  word_t    in_operand_i,
  output logic     in_ready_o,

  // Response to the core
  input  logic     c_p_ready_i,
  output logic     c_p_valid_o,
  output word_t    c_p_data_o,

  // Memory request
  input  logic     cmem_q_ready_i,
  output logic     cmem_q_valid_o,
  output mem_req_e cmem_q_type_o,
  output word_t    cmem_q_addr_o,
  output word_t    cmem_q_wdata_o,

  // Memory response, always accepted
  input  logic     cmem_p_valid_i,
  input  word_t    cmem_p_data_i
);

  instr_t head_instr;
  word_t  head_operand;
  logic   pop_valid;
  logic   pop_ready;

  logic   exec_in_valid;
  logic   exec_out_valid;
  logic   exec_out_ready;
  word_t  exec_result;

  word_t  rs1;
  word_t  rs2;
  logic   fpr_we;
  logic   csr_we;

  fpss_dec_if dec_if ();

  fpss_instr_fifo u_fifo (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_valid_i   (in_valid_i),
    .push_instr_i   (in_instr_i),
    .push_operand_i (in_operand_i),
    .pop_ready_i    (pop_ready),
    .push_ready_o   (in_ready_o),
    .pop_valid_o    (pop_valid),
    .pop_instr_o    (head_instr),
    .pop_operand_o  (head_operand)
  );

  fpss_decoder u_decoder (
    .instr_i (head_instr),
    .dec     (dec_if)
  );

  fpss_controller u_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dec              (dec_if),
    .pop_valid_i      (pop_valid),
    .pop_ready_o      (pop_ready),
    .exec_out_valid_i (exec_out_valid),
    .exec_in_valid_o  (exec_in_valid),
    .exec_out_ready_o (exec_out_ready),
    .fpr_we_o         (fpr_we),
    .csr_we_o         (csr_we),
    .c_p_ready_i      (c_p_ready_i),
    .c_p_valid_o      (c_p_valid_o),
    .cmem_q_ready_i   (cmem_q_ready_i),
    .cmem_p_valid_i   (cmem_p_valid_i),
    .cmem_q_valid_o   (cmem_q_valid_o),
    .cmem_q_type_o    (cmem_q_type_o)
  );

  // Operands sampled at issue from the head entry
  fpss_exec_unit u_exec (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (exec_in_valid),
    .op_i        (opcode_e'(head_instr[OPC_MSB:OPC_LSB])),
    .a_i         (rs1),
    .b_i         (rs2),
    .operand_i   (head_operand),
    .out_ready_i (exec_out_ready),
    .out_valid_o (exec_out_valid),
    .result_o    (exec_result)
  );

  fpss_regfile u_rf (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .dec           (dec_if),
    .instr_i       (head_instr),
    .operand_i     (head_operand),
    .exec_result_i (exec_result),
    .mem_rdata_i   (cmem_p_data_i),
    .fpr_we_i      (fpr_we),
    .csr_we_i      (csr_we),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .c_data_o      (c_p_data_o)
  );

  // Address from the integer operand, store data from rs2
  assign cmem_q_addr_o  = head_operand;
  assign cmem_q_wdata_o = rs2;

endmodule

//--- src/fpss_regfile.sv
`timescale 1ns/10ps

module fpss_regfile import fpss_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  fpss_dec_if.rf dec,
  input  instr_t instr_i,
  input  word_t  operand_i,
  input  word_t  exec_result_i,
  input  word_t  mem_rdata_i,
  input  logic   fpr_we_i,
  input  logic   csr_we_i,
  output word_t  rs1_o,
  output word_t  rs2_o,
  output word_t  c_data_o
);

  word_t    fpr_q [NUM_FPR];
  // Single scratch CSR
  word_t    csr_q;

  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    wdata;

  // Register fields of the head instruction
  assign rd  = instr_i[RD_MSB:RD_LSB];
  assign rs1 = instr_i[RS1_MSB:RS1_LSB];
  assign rs2 = instr_i[RS2_MSB:RS2_LSB];

  assign rs1_o = fpr_q[rs1];
  assign rs2_o = fpr_q[rs2];

  // Load data or unit result into rd
  assign wdata = dec.is_load ? mem_rdata_i : exec_result_i;

  // Old CSR value goes back to the core on a CSR access
  assign c_data_o = dec.is_csr ? csr_q : exec_result_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_FPR; i++) begin
        fpr_q[i] <= '0;
      end
      csr_q <= '0;
    end else begin
      if (fpr_we_i) begin
        fpr_q[rd] <= wdata;
      end
      // Written on the response handshake
      if (csr_we_i) begin
        csr_q <= operand_i;
      end
    end
  end

endmodule

//--- src/fpss_exec_unit.sv
`timescale 1ns/10ps

module fpss_exec_unit import fpss_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    in_valid_i,
  input  opcode_e op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  input  word_t   operand_i,
  input  logic    out_ready_i,
  output logic    out_valid_o,
  output word_t   result_o
);

  logic [EXEC_LAT-1:0] valid_q;
  word_t               res_q [EXEC_LAT];
  // Stage k can take new data this cycle
  logic [EXEC_LAT-1:0] adv;
  word_t               result_d;

  // Integer stand-in for the FP datapath
  always_comb begin
    case (op_i)
      OP_ADD:  result_d = a_i + b_i;
      OP_MUL:  result_d = word_t'(a_i * b_i);
      OP_MVW:  result_d = operand_i;
      OP_MVX:  result_d = a_i;
      default: result_d = '0;
    endcase
  end

  // Back-pressure ripples from the last stage towards the input
  always_comb begin
    adv[EXEC_LAT-1] = ~valid_q[EXEC_LAT-1] | out_ready_i;
    for (int k = EXEC_LAT - 2; k >= 0; k--) begin
      adv[k] = ~valid_q[k] | adv[k+1];
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      if (adv[0]) begin
        valid_q[0] <= in_valid_i;
      end
      for (int k = 1; k < EXEC_LAT; k++) begin
        if (adv[k]) begin
          valid_q[k] <= valid_q[k-1];
        end
      end
    end
  end

  // Result payload follows its valid bit
  always_ff @(posedge clk_i) begin
    if (adv[0] && in_valid_i) begin
      res_q[0] <= result_d;
    end
    for (int k = 1; k < EXEC_LAT; k++) begin
      if (adv[k] && valid_q[k-1]) begin
        res_q[k] <= res_q[k-1];
      end
    end
  end

  assign out_valid_o = valid_q[EXEC_LAT-1];
  assign result_o    = res_q[EXEC_LAT-1];

endmodule

//--- src/fpss_controller.sv
`timescale 1ns/10ps

module fpss_controller import fpss_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  fpss_dec_if.ctrl  dec,

  // Buffer head
  input  logic      pop_valid_i,
  output logic      pop_ready_o,

  // Execution unit handshakes
  input  logic      exec_out_valid_i,
  output logic      exec_in_valid_o,
  output logic      exec_out_ready_o,

  // Register file writes
  output logic      fpr_we_o,
  output logic      csr_we_o,

  // Core response channel
  input  logic      c_p_ready_i,
  output logic      c_p_valid_o,

  // Memory request and response
  input  logic      cmem_q_ready_i,
  input  logic      cmem_p_valid_i,
  output logic      cmem_q_valid_o,
  output mem_req_e  cmem_q_type_o
);

  logic inflight_d;
  logic inflight_q;
  logic offloaded_d;
  logic offloaded_q;

  // Stage 0 is the combinational CSR-at-head flag
  logic [INT_WB_DELAY:0] delay_d;
  logic [INT_WB_DELAY:0] delay_q;
  logic                  int_wb;

  logic c_rsp_hs;
  logic mem_req_hs;
  logic load_rsp;
  logic exec_fp_done;

  assign c_rsp_hs     = c_p_valid_o & c_p_ready_i;
  assign mem_req_hs   = cmem_q_valid_o & cmem_q_ready_i;
  // Load data only counts once its request went out
  assign load_rsp     = pop_valid_i & dec.is_load & offloaded_q & cmem_p_valid_i;
  assign exec_fp_done = pop_valid_i & exec_out_valid_i & dec.rd_is_fp;

  // Retire on FP result, core response, store request or load data
  assign pop_ready_o = exec_fp_done | c_rsp_hs | (mem_req_hs & dec.is_store) | load_rsp;

  // Issue once, in the first head cycle
  assign exec_in_valid_o  = pop_valid_i & dec.use_exec & ~inflight_q;
  // Unit holds its result until the instruction leaves the head
  assign exec_out_ready_o = pop_ready_o & dec.use_exec;

  assign fpr_we_o = exec_fp_done | load_rsp;
  assign csr_we_o = c_rsp_hs & dec.is_csr;

  // Response from the unit for MVX, or the delayed CSR writeback
  assign c_p_valid_o = pop_valid_i & ((exec_out_valid_i & ~dec.rd_is_fp) | int_wb);

  assign cmem_q_valid_o = pop_valid_i & (dec.is_load | dec.is_store) & ~offloaded_q;
  assign cmem_q_type_o  = dec.is_store ? MEM_WRITE : MEM_READ;

  always_comb begin
    inflight_d = inflight_q;
    if (pop_ready_o) begin
      inflight_d = 1'b0;
    end else if (exec_in_valid_o) begin
      inflight_d = 1'b1;
    end
  end

  // Store pops in the request cycle, so pop wins over set
  always_comb begin
    offloaded_d = offloaded_q;
    if (pop_ready_o) begin
      offloaded_d = 1'b0;
    end else if (mem_req_hs) begin
      offloaded_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q  <= 1'b0;
      offloaded_q <= 1'b0;
    end else begin
      inflight_q  <= inflight_d;
      offloaded_q <= offloaded_d;
    end
  end

  // CSR writeback delay chain
  assign delay_q[0] = pop_valid_i & dec.is_csr;
  assign delay_d[0] = delay_q[0];

  for (genvar i = 0; i < INT_WB_DELAY; i++) begin : g_wb_delay
    // Chain empties when the instruction retires
    assign delay_d[i+1] = pop_ready_o ? 1'b0 : delay_q[i];

    always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
        delay_q[i+1] <= 1'b0;
      end else begin
        delay_q[i+1] <= delay_d[i+1];
      end
    end
  end

  assign int_wb = delay_q[INT_WB_DELAY] & delay_d[0];

endmodule

//--- src/fpss_decoder.sv
`timescale 1ns/10ps

module fpss_decoder import fpss_pkg::*; (
  input instr_t     instr_i,
  fpss_dec_if.dec   dec
);

  opcode_e opcode;

  assign opcode = opcode_e'(instr_i[OPC_MSB:OPC_LSB]);

  always_comb begin
    // Unknown opcodes decode to no class at all
    dec.use_exec = 1'b0;
    dec.rd_is_fp = 1'b0;
    dec.is_load  = 1'b0;
    dec.is_store = 1'b0;
    dec.is_csr   = 1'b0;
    case (opcode)
      OP_ADD, OP_MUL, OP_MVW: begin
        dec.use_exec = 1'b1;
        dec.rd_is_fp = 1'b1;
      end
      // Move to core goes through the unit but answers on the response channel
      OP_MVX: begin
        dec.use_exec = 1'b1;
      end
      OP_LOAD: begin
        dec.rd_is_fp = 1'b1;
        dec.is_load  = 1'b1;
      end
      OP_STORE: begin
        dec.is_store = 1'b1;
      end
      OP_CSRW: begin
        dec.is_csr = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- src/fpss_instr_fifo.sv
`timescale 1ns/10ps

module fpss_instr_fifo import fpss_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   push_valid_i,
  input  instr_t push_instr_i,
  input  word_t  push_operand_i,
  input  logic   pop_ready_i,
  output logic   push_ready_o,
  output logic   pop_valid_o,
  output instr_t pop_instr_o,
  output word_t  pop_operand_o
);

  // Entry storage
  instr_t instr_q [FIFO_DEPTH];
  word_t  operand_q [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] cnt_q;

  logic push;
  logic pop;

  // Room left while fewer than FIFO_DEPTH entries held
  assign push_ready_o = (cnt_q < FIFO_CNT_W'(FIFO_DEPTH));
  assign pop_valid_o  = (cnt_q != '0);

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_ready_i & pop_valid_o;

  // Head entry straight from storage
  assign pop_instr_o   = instr_q[rd_ptr_q];
  assign pop_operand_o = operand_q[rd_ptr_q];

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        // Wrap at the last slot
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count stays put on simultaneous push and pop
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Payload write
  always_ff @(posedge clk_i) begin
    if (push) begin
      instr_q[wr_ptr_q]   <= push_instr_i;
      operand_q[wr_ptr_q] <= push_operand_i;
    end
  end

endmodule

//--- src/fpss_dec_if.sv
`timescale 1ns/10ps

interface fpss_dec_if;

  // Class flags of the instruction at the buffer head
  logic use_exec;
  logic rd_is_fp;
  logic is_load;
  logic is_store;
  logic is_csr;

  modport dec (output use_exec, output rd_is_fp, output is_load, output is_store, output is_csr);

  modport ctrl (input use_exec, input rd_is_fp, input is_load, input is_store, input is_csr);

  // Register file only needs the data source selects
  modport rf (input is_load, input is_csr);

endinterface

//--- src/fpss_pkg.sv
package fpss_pkg;

  // Offload buffer depth and its derived widths
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Execution unit latency in cycles
  localparam int unsigned EXEC_LAT = 2;

  // Head cycles before a CSR response goes valid
  localparam int unsigned INT_WB_DELAY = 1;

  // FP register file size
  localparam int unsigned NUM_FPR = 8;

  // Data word used for registers, operands, results and addresses
  typedef logic [31:0] word_t;

  // FP register index
  typedef logic [2:0] reg_idx_t;

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_MUL   = 3'd1,
    OP_MVW   = 3'd2,
    OP_MVX   = 3'd3,
    OP_LOAD  = 3'd4,
    OP_STORE = 3'd5,
    OP_CSRW  = 3'd6
  } opcode_e;

  // Instruction word: opcode, rd, rs1, rs2 from MSB down
  typedef logic [11:0] instr_t;

  localparam int unsigned OPC_MSB = 11;
  localparam int unsigned OPC_LSB = 9;
  localparam int unsigned RD_MSB  = 8;
  localparam int unsigned RD_LSB  = 6;
  localparam int unsigned RS1_MSB = 5;
  localparam int unsigned RS1_LSB = 3;
  localparam int unsigned RS2_MSB = 2;
  localparam int unsigned RS2_LSB = 0;

  // Memory request direction
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_req_e;

endpackage
